//--- all.f
+incdir+include
hdl/vp_pkg.sv
hdl/vp_sys_ctrl.sv
hdl/vp_clk_enables.sv
hdl/vp_cart_rom.sv
hdl/vp_key_xlate.sv
hdl/vp_palette.sv
hdl/vp_core_top.sv
bench/vp_checker.sv
bench/vp_tb.sv

//--- bench/vp_checker.sv
// Watches the DUT outputs at the falling clock edge
// Expectations come from the testbench model with one enable per check group
// Enable spacing is measured only while en_chk_i is held high
module vp_checker (
	input  logic        clk_sys,
	input  logic        reset,
	// Enable spacing
	input  logic        en_chk_i,
	input  int          cpu_div_i,
	input  int          pix_div_i,
	input  logic        cpu_en_i,
	input  logic        pix_en_i,
	// System reset during download
	input  logic        sysrst_chk_i,
	input  logic        sys_reset_i,
	// Cartridge reads
	input  logic        rd_chk_i,
	input  logic [7:0]  rd_exp_i,
	input  logic [7:0]  cart_data_i,
	input  logic        cart_data_valid_i,
	// Key events
	input  logic        key_chk_i,
	input  logic [7:0]  key_exp_ascii_i,
	input  logic        key_exp_rel_i,
	input  logic        key_valid_i,
	input  logic [7:0]  key_ascii_i,
	input  logic        key_released_i,
	// Palette
	input  logic        rgb_chk_i,
	input  logic [23:0] rgb_exp_i,
	input  logic [23:0] rgb_i,
	output int          error_count_o
);
	int   cpu_gap;
	int   pix_gap;
	logic cpu_prev;
	logic pix_prev;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			error_count_o = error_count_o + 1;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	initial begin
		error_count_o = 0;
		cpu_gap = 0;
		pix_gap = 0;
		cpu_prev = 1'b0;
		pix_prev = 1'b0;
	end

	////////////////////
	// Comparisons
	////////////////////

	always @(negedge clk_sys) begin
		if (!reset) begin
			// Gap counts cycles since the previous pulse
			if (cpu_en_i) begin
				if (en_chk_i && cpu_prev) begin
					compare("cpu_en_o spacing", 32'(cpu_gap), 32'(cpu_div_i));
				end
				cpu_gap = 1;
				cpu_prev = en_chk_i;
			end else begin
				cpu_gap = cpu_gap + 1;
			end
			if (pix_en_i) begin
				if (en_chk_i && pix_prev) begin
					compare("pix_en_o spacing", 32'(pix_gap), 32'(pix_div_i));
				end
				pix_gap = 1;
				pix_prev = en_chk_i;
			end else begin
				pix_gap = pix_gap + 1;
			end
			// Standard change or download restarts the measurement
			if (!en_chk_i) begin
				cpu_prev = 1'b0;
				pix_prev = 1'b0;
			end

			if (sysrst_chk_i) begin
				compare("sys_reset_o", 32'(sys_reset_i), 32'd1);
			end
			// Valid only in the cycle after each read strobe
			compare("cart_data_valid_o", 32'(cart_data_valid_i), 32'(rd_chk_i));
			if (rd_chk_i) begin
				compare("cart_data_o", 32'(cart_data_i), 32'(rd_exp_i));
			end
			// Event must hold until accepted
			if (key_chk_i) begin
				compare("key_valid_o", 32'(key_valid_i), 32'd1);
				compare("key_ascii_o", 32'(key_ascii_i), 32'(key_exp_ascii_i));
				compare("key_released_o", 32'(key_released_i), 32'(key_exp_rel_i));
			end
			if (rgb_chk_i) begin
				compare("rgb_o", 32'(rgb_i), 32'(rgb_exp_i));
			end
		end
	end

endmodule

//--- bench/vp_tb.sv
// Testbench of the Videopac glue logic with LFSR driven random stimulus
// Inputs change on the rising edge and the checker samples on the falling one
// Waits give up after a cycle limit of their own
module vp_tb;
	import vp_pkg::*;

	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int PIX_DIV_NTSC = 6;
	localparam int PIX_DIV_PAL  = 10;
	localparam int KEY_N        = 46;
	// Scan codes in the same order as their characters below
	localparam logic [8*KEY_N-1:0] KEY_CODES = {
		8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e, 8'h36, 8'h3d, 8'h3e, 8'h46, 8'h45,
		8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43, 8'h3b,
		8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d, 8'h1b, 8'h2c,
		8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a, 8'h29, 8'h79, 8'h7b, 8'h7c,
		8'h4a, 8'h55, 8'h1f, 8'h27, 8'h5a, 8'h66};
	localparam logic [8*KEY_N-1:0] KEY_CHARS = {
		"1234567890abcdefghijklmnopqrstuvwxyz +-*/=", 8'h11, 8'h12, 8'd10, 8'd8};
	localparam int SIG_SYS = 0;
	localparam int SIG_KEY = 1;
	localparam int SIG_PIX = 2;

	logic clk_sys, reset, pal, dl_active, dl_wr, dl_xrom, cart_rd, bank0, bank1;
	logic key_strobe, key_pressed, key_ready;
	logic [ROM_AW-1:0]   dl_addr;
	logic [7:0]          dl_data;
	logic [CART_AW-1:0]  cart_addr;
	logic [SCAN_W-1:0]   key_code;
	logic [NUMPAD_W-1:0] joy_num;
	logic [3:0]          rgbl;
	logic [2:0]          contrast;
	logic sys_reset_o, cpu_en_o, pix_en_o, cart_data_valid_o, key_valid_o, key_released_o;
	logic [7:0]  cart_data_o;
	logic [7:0]  key_ascii_o;
	logic [23:0] rgb_o;
	// Checker controls and expectations
	logic en_chk, sysrst_chk, rd_chk, key_chk, rgb_chk, key_exp_rel;
	logic [7:0]  rd_exp;
	logic [7:0]  key_exp_ascii;
	logic [23:0] rgb_exp;
	int          cpu_div, pix_div, error_count, timeouts;
	logic [31:0] lfsr_state;
	// Model of the ROM contents and the download result
	logic [7:0]  model_mem [2 ** ROM_AW];
	int          model_size;
	logic        model_xrom;

	////////////////////
	// Model
	////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] code_at(input int i);
		return 8'(KEY_CODES >> (8 * (KEY_N - 1 - i)));
	endfunction

	function automatic logic [7:0] ascii_of(input logic [8:0] code);
		int i;
		for (i = 0; i < KEY_N; i++) begin
			if (code[7:0] == code_at(i)) begin
				return 8'(KEY_CHARS >> (8 * (KEY_N - 1 - i)));
			end
		end
		return 8'h00;
	endfunction

	// Lowest pressed button wins and bit 9 is the zero key
	function automatic logic [7:0] digit_of(input logic [9:0] pat);
		int i;
		for (i = 0; i < 10; i++) begin
			if (pat[i]) begin
				return (i == 9) ? 8'd48 : 8'(49 + i);
			end
		end
		return 8'h00;
	endfunction

	// Bit 10 of the console address is skipped below 12K
	function automatic logic [13:0] map_addr(input logic [11:0] a, input logic b0,
			input logic b1);
		logic [13:0] low;
		low = 14'({a[11], a[9:0]});
		if (model_xrom) begin
			return 14'(a);
		end
		case (model_size)
			1: return low + (b0 ? 14'd2048 : 14'd0);
			2: return low + (b0 ? 14'd2048 : 14'd0) + (b1 ? 14'd4096 : 14'd0);
			3: return 14'(a) + (b0 ? 14'd4096 : 14'd0) + (b1 ? 14'd8192 : 14'd0);
			default: return low;
		endcase
	endfunction

	// Lead channel keeps its top bits and gaps take the top k bits of tail and green
	function automatic logic [23:0] model_rgb(input logic [3:0] idx, input logic [2:0] c);
		logic [23:0] base;
		logic [7:0]  lead, tail, grn, r, g;
		int          k;
		base = PALETTE[idx];
		grn  = base[15:8];
		lead = (c > 3'd4) ? base[7:0] : base[23:16];
		tail = (c > 3'd4) ? base[23:16] : base[7:0];
		case (c)
			3'd1, 3'd7: k = 1;
			3'd2, 3'd6: k = 2;
			3'd3, 3'd5: k = 4;
			default: return base;
		endcase
		r = (lead & ~(8'hff >> (8 - k))) | (tail >> (8 - k));
		g = (grn & ~(8'hff >> k)) | (lead >> k);
		return {r, g, r};
	endfunction

	function automatic logic probe(input int which);
		case (which)
			SIG_SYS: return sys_reset_o;
			SIG_KEY: return key_valid_o;
			default: return pix_en_o;
		endcase
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	task automatic wait_level(input int which, input logic level, input int limit,
			input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (probe(which) !== level && n < limit) begin
			n++;
			@(negedge clk_sys);
		end
		if (probe(which) !== level) begin
			timeouts++;
			$display("Timeout at %0t while waiting for %s", $time, what);
		end
	endtask

	task automatic run_enables(input logic pal_val);
		logic changed;
		changed = (pal_val != pal);
		@(posedge clk_sys);
		en_chk  <= 1'b0;
		pal     <= pal_val;
		cpu_div <= pal_val ? CPU_DIV_PAL : CPU_DIV_NTSC;
		pix_div <= pal_val ? PIX_DIV_PAL : PIX_DIV_NTSC;
		// Standard change pulses the system reset
		if (changed) begin
			wait_level(SIG_SYS, 1'b1, 10, "sys_reset_o after a pal_i change");
			wait_level(SIG_SYS, 1'b0, 10, "sys_reset_o to fall");
		end
		repeat (2) @(posedge clk_sys);
		en_chk <= 1'b1;
		repeat (100) @(posedge clk_sys);
		en_chk <= 1'b0;
	endtask

	task automatic download(input int nbytes, input logic x);
		int          i;
		logic [7:0]  d;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_xrom   <= x;
		for (i = 0; i < nbytes; i++) begin
			@(posedge clk_sys);
			d = 8'(take_bits(8));
			dl_wr      <= 1'b1;
			dl_addr    <= ROM_AW'(i);
			dl_data    <= d;
			sysrst_chk <= 1'b1;
			model_mem[ROM_AW'(i)] = d;
		end
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		@(posedge clk_sys);
		dl_active  <= 1'b0;
		sysrst_chk <= 1'b0;
		case (nbytes)
			4096: model_size = 1;
			8192: model_size = 2;
			16384: model_size = 3;
			default: model_size = 0;
		endcase
		model_xrom = x;
		repeat (3) @(posedge clk_sys);
	endtask

	// Data of read i is checked while read i+1 is driven
	task automatic read_back(input int n);
		int          i;
		logic [11:0] a;
		logic        b0, b1;
		logic [7:0]  pend;
		pend = '0;
		for (i = 0; i <= n; i++) begin
			@(posedge clk_sys);
			rd_chk <= (i > 0);
			rd_exp <= pend;
			if (i < n) begin
				a  = 12'(take_bits(12));
				b0 = take_bits(1) != 0;
				b1 = take_bits(1) != 0;
				cart_rd   <= 1'b1;
				cart_addr <= a;
				bank0     <= b0;
				bank1     <= b1;
				pend = model_mem[map_addr(a, b0, b1)];
			end else begin
				cart_rd <= 1'b0;
			end
		end
		@(posedge clk_sys);
		rd_chk <= 1'b0;
	endtask

	task automatic send_key_event(input logic is_joy);
		logic [8:0] code;
		logic [9:0] pat;
		logic       pressed;
		int         gap;
		@(posedge clk_sys);
		if (!is_joy) begin
			// Half the codes come from the table
			if (take_bits(1) != 0) begin
				code = {take_bits(1) != 0, code_at(int'(take_bits(6)) % KEY_N)};
			end else begin
				code = 9'(take_bits(9));
			end
			pressed = take_bits(1) != 0;
			key_code      <= code;
			key_pressed   <= pressed;
			key_strobe    <= ~key_strobe;
			key_exp_ascii <= ascii_of(code);
			key_exp_rel   <= ~pressed;
		end else begin
			pat = (take_bits(2) == 0) ? 10'd0 : 10'(take_bits(10));
			if (pat == joy_num) begin
				pat = pat ^ 10'd1;
			end
			joy_num       <= pat;
			key_exp_ascii <= digit_of(pat);
			key_exp_rel   <= (pat == 10'd0);
		end
		wait_level(SIG_KEY, 1'b1, 10, "key_valid_o for a new event");
		gap = int'(take_bits(2));
		repeat (gap) begin
			@(posedge clk_sys);
			key_chk <= 1'b1;
		end
		@(posedge clk_sys);
		key_chk   <= 1'b1;
		key_ready <= 1'b1;
		@(posedge clk_sys);
		key_chk   <= 1'b0;
		key_ready <= 1'b0;
		wait_level(SIG_KEY, 1'b0, 4, "key_valid_o to fall after key_ready_i");
	endtask

	// Expected colour must hold until the edge after the next pixel enable
	task automatic run_palette(input int n);
		int          i;
		logic [23:0] exp;
		for (i = 0; i < n; i++) begin
			wait_level(SIG_PIX, 1'b1, 16, "pix_en_o");
			exp = model_rgb(rgbl, contrast);
			@(posedge clk_sys);
			rgb_chk  <= 1'b1;
			rgb_exp  <= exp;
			rgbl     <= 4'(take_bits(4));
			contrast <= 3'(take_bits(3));
		end
		@(posedge clk_sys);
		rgb_chk <= 1'b0;
	endtask

	////////////////////
	// DUT and checker
	////////////////////

	vp_core_top #(
		.CPU_DIV_NTSC(CPU_DIV_NTSC),
		.CPU_DIV_PAL (CPU_DIV_PAL),
		.PIX_DIV_NTSC(PIX_DIV_NTSC),
		.PIX_DIV_PAL (PIX_DIV_PAL)
	) i_vp_core_top (
		.clk_sys(clk_sys), .reset(reset), .pal_i(pal),
		.dl_active_i(dl_active), .dl_wr_i(dl_wr), .dl_addr_i(dl_addr),
		.dl_data_i(dl_data), .dl_xrom_i(dl_xrom),
		.cart_rd_i(cart_rd), .cart_addr_i(cart_addr), .bank0_i(bank0), .bank1_i(bank1),
		.key_strobe_i(key_strobe), .key_pressed_i(key_pressed), .key_code_i(key_code),
		.joy_num_i(joy_num), .key_ready_i(key_ready),
		.rgbl_i(rgbl), .contrast_i(contrast),
		.sys_reset_o(sys_reset_o), .cpu_en_o(cpu_en_o), .pix_en_o(pix_en_o),
		.cart_data_o(cart_data_o), .cart_data_valid_o(cart_data_valid_o),
		.key_valid_o(key_valid_o), .key_ascii_o(key_ascii_o),
		.key_released_o(key_released_o), .rgb_o(rgb_o)
	);

	vp_checker i_checker (
		.clk_sys(clk_sys), .reset(reset),
		.en_chk_i(en_chk), .cpu_div_i(cpu_div), .pix_div_i(pix_div),
		.cpu_en_i(cpu_en_o), .pix_en_i(pix_en_o),
		.sysrst_chk_i(sysrst_chk), .sys_reset_i(sys_reset_o),
		.rd_chk_i(rd_chk), .rd_exp_i(rd_exp), .cart_data_i(cart_data_o),
		.cart_data_valid_i(cart_data_valid_o),
		.key_chk_i(key_chk), .key_exp_ascii_i(key_exp_ascii), .key_exp_rel_i(key_exp_rel),
		.key_valid_i(key_valid_o), .key_ascii_i(key_ascii_o),
		.key_released_i(key_released_o),
		.rgb_chk_i(rgb_chk), .rgb_exp_i(rgb_exp), .rgb_i(rgb_o),
		.error_count_o(error_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		int sizes [4];
		int s;
		int x;
		sizes = '{16384, 2048, 4096, 8192};
		lfsr_state = 32'h8f1dde1e;
		timeouts = 0;
		reset = 1'b1;
		{pal, dl_active, dl_wr, dl_xrom, cart_rd, bank0, bank1} = '0;
		{key_strobe, key_pressed, key_ready} = '0;
		dl_addr = '0;
		dl_data = '0;
		cart_addr = '0;
		key_code = '0;
		joy_num = '0;
		rgbl = '0;
		contrast = '0;
		{en_chk, sysrst_chk, rd_chk, key_chk, rgb_chk, key_exp_rel} = '0;
		rd_exp = '0;
		key_exp_ascii = '0;
		rgb_exp = '0;
		cpu_div = CPU_DIV_NTSC;
		pix_div = PIX_DIV_NTSC;
		model_size = 0;
		model_xrom = 1'b0;
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;

		run_enables(1'b0);
		run_enables(1'b1);
		run_enables(1'b0);
		// Full image first so every mapped byte is known
		for (s = 0; s < 4; s++) begin
			for (x = 0; x < 2; x++) begin
				download(sizes[s], x != 0);
				read_back(120);
			end
		end
		repeat (60) send_key_event(1'b0);
		repeat (40) send_key_event(1'b1);
		run_palette(80);

		repeat (4) @(posedge clk_sys);
		$display("Errors: %0d mismatches, %0d timeouts", error_count, timeouts);
		if (error_count == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- hdl/vp_cart_rom.sv
// Cartridge ROM, 16 KiB, written at the raw download address
// Reads follow cart_rd_i alone, data one cycle later with cart_data_valid_o
// A write and a read of the same byte on one edge return the old byte
`include "vp_defs.svh"

module vp_cart_rom (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_wr_i,
	input  logic [vp_pkg::ROM_AW-1:0]  dl_addr_i,
	input  logic [`VP_DATA_W-1:0]      dl_data_i,
	input  logic                       cart_rd_i,
	input  logic [vp_pkg::CART_AW-1:0] cart_addr_i,
	input  logic                       bank0_i,
	input  logic                       bank1_i,
	input  vp_pkg::size_class_e        size_class_i,
	input  logic                       xrom_i,
	output logic [`VP_DATA_W-1:0]      cart_data_o,
	output logic                       cart_data_valid_o
);
	import vp_pkg::*;

	logic [`VP_DATA_W-1:0] mem [2 ** ROM_AW];
	logic [ROM_AW-1:0]     rd_addr;

	////////////////////
	// Bank mapping
	////////////////////

	// Address bit 10 selects internal RAM on the console, so it is skipped
	// below 12K, where the image is packed in 2K halves per bank
	always_comb begin
		if (xrom_i) begin
			// XROM sees a flat 4K window
			rd_addr = ROM_AW'(cart_addr_i);
		end else begin
			case (size_class_i)
				SIZE_4K: rd_addr = ROM_AW'({1'b0, bank0_i, cart_addr_i[11], cart_addr_i[9:0]});
				SIZE_8K: rd_addr = ROM_AW'({bank1_i, bank0_i, cart_addr_i[11], cart_addr_i[9:0]});
				// Full 4K per bank, four banks
				SIZE_12K: rd_addr = ROM_AW'({bank1_i, bank0_i, cart_addr_i[11:0]});
				default: rd_addr = ROM_AW'({1'b0, cart_addr_i[11], cart_addr_i[9:0]});
			endcase
		end
	end

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (dl_wr_i) begin
			mem[dl_addr_i] <= dl_data_i;
		end
		if (cart_rd_i) begin
			cart_data_o <= mem[rd_addr];
		end
	end

	// Read strobe delayed to match the data
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cart_data_valid_o <= 1'b0;
		end else begin
			cart_data_valid_o <= cart_rd_i;
		end
	end

endmodule

//--- hdl/vp_clk_enables.sv
// CPU and pixel clock enables from clk_sys
// Divisors swap with pal_i on the fly, a shorter divisor wraps at once
// First pulse comes DIV cycles after core_reset_i drops
module vp_clk_enables #(
	parameter int CPU_DIV_NTSC = 8,
	parameter int CPU_DIV_PAL  = 12,
	parameter int PIX_DIV_NTSC = 6,
	parameter int PIX_DIV_PAL  = 10
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic core_reset_i,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic pix_en_o
);
	// Counters sized for the larger divisor of each pair
	localparam int CPU_MAX = (CPU_DIV_PAL > CPU_DIV_NTSC) ? CPU_DIV_PAL : CPU_DIV_NTSC;
	localparam int PIX_MAX = (PIX_DIV_PAL > PIX_DIV_NTSC) ? PIX_DIV_PAL : PIX_DIV_NTSC;
	localparam int CPU_W   = $clog2(CPU_MAX);
	localparam int PIX_W   = $clog2(PIX_MAX);

	logic [CPU_W-1:0] cpu_cnt;
	logic [CPU_W-1:0] cpu_last;
	logic [PIX_W-1:0] pix_cnt;
	logic [PIX_W-1:0] pix_last;

	// Terminal count per standard
	assign cpu_last = pal_i ? CPU_W'(CPU_DIV_PAL - 1) : CPU_W'(CPU_DIV_NTSC - 1);
	assign pix_last = pal_i ? PIX_W'(PIX_DIV_PAL - 1) : PIX_W'(PIX_DIV_NTSC - 1);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= '0;
			pix_cnt  <= '0;
			cpu_en_o <= 1'b0;
			pix_en_o <= 1'b0;
		end else if (core_reset_i) begin
			cpu_cnt  <= '0;
			pix_cnt  <= '0;
			cpu_en_o <= 1'b0;
			pix_en_o <= 1'b0;
		end else begin
			// Pulse on wrap
			cpu_en_o <= (cpu_cnt >= cpu_last);
			cpu_cnt  <= (cpu_cnt >= cpu_last) ? '0 : cpu_cnt + CPU_W'(1);
			pix_en_o <= (pix_cnt >= pix_last);
			pix_cnt  <= (pix_cnt >= pix_last) ? '0 : pix_cnt + PIX_W'(1);
		end
	end

endmodule

//--- hdl/vp_core_top.sv
// Glue logic of the Videopac core, CPU and VDC sit outside
// Divisors are in clk_sys cycles, PAL chosen by pal_i
// ROM reads follow cart_rd_i with no chip select
`include "vp_defs.svh"

module vp_core_top #(
	parameter int CPU_DIV_NTSC = 8,
	parameter int CPU_DIV_PAL  = 12,
	parameter int PIX_DIV_NTSC = 6,
	parameter int PIX_DIV_PAL  = 10
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        pal_i,
	// Download port
	input  logic                        dl_active_i,
	input  logic                        dl_wr_i,
	input  logic [vp_pkg::ROM_AW-1:0]   dl_addr_i,
	input  logic [`VP_DATA_W-1:0]       dl_data_i,
	input  logic                        dl_xrom_i,
	// Cartridge bus
	input  logic                        cart_rd_i,
	input  logic [vp_pkg::CART_AW-1:0]  cart_addr_i,
	input  logic                        bank0_i,
	input  logic                        bank1_i,
	// Keyboard and numpad
	input  logic                        key_strobe_i,
	input  logic                        key_pressed_i,
	input  logic [vp_pkg::SCAN_W-1:0]   key_code_i,
	input  logic [vp_pkg::NUMPAD_W-1:0] joy_num_i,
	input  logic                        key_ready_i,
	// Video
	input  logic [3:0]                  rgbl_i,
	input  logic [2:0]                  contrast_i,
	output logic                        sys_reset_o,
	output logic                        cpu_en_o,
	output logic                        pix_en_o,
	output logic [`VP_DATA_W-1:0]       cart_data_o,
	output logic                        cart_data_valid_o,
	output logic                        key_valid_o,
	output logic [7:0]                  key_ascii_o,
	output logic                        key_released_o,
	output logic [23:0]                 rgb_o
);
	import vp_pkg::*;

	logic        core_reset;
	logic        xrom;
	logic        pix_en;
	size_class_e size_class;

	assign pix_en_o = pix_en;

	vp_sys_ctrl i_vp_sys_ctrl (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pal_i       (pal_i),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_xrom_i   (dl_xrom_i),
		.sys_reset_o (sys_reset_o),
		.core_reset_o(core_reset),
		.size_class_o(size_class),
		.xrom_o      (xrom)
	);

	vp_clk_enables #(
		.CPU_DIV_NTSC(CPU_DIV_NTSC),
		.CPU_DIV_PAL (CPU_DIV_PAL),
		.PIX_DIV_NTSC(PIX_DIV_NTSC),
		.PIX_DIV_PAL (PIX_DIV_PAL)
	) i_vp_clk_enables (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.core_reset_i(core_reset),
		.pal_i       (pal_i),
		.cpu_en_o    (cpu_en_o),
		.pix_en_o    (pix_en)
	);

	vp_cart_rom i_vp_cart_rom (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.dl_wr_i          (dl_wr_i),
		.dl_addr_i        (dl_addr_i),
		.dl_data_i        (dl_data_i),
		.cart_rd_i        (cart_rd_i),
		.cart_addr_i      (cart_addr_i),
		.bank0_i          (bank0_i),
		.bank1_i          (bank1_i),
		.size_class_i     (size_class),
		.xrom_i           (xrom),
		.cart_data_o      (cart_data_o),
		.cart_data_valid_o(cart_data_valid_o)
	);

	vp_key_xlate i_vp_key_xlate (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.core_reset_i  (core_reset),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.joy_num_i     (joy_num_i),
		.key_ready_i   (key_ready_i),
		.key_valid_o   (key_valid_o),
		.key_ascii_o   (key_ascii_o),
		.key_released_o(key_released_o)
	);

	vp_palette i_vp_palette (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.core_reset_i(core_reset),
		.pix_en_i    (pix_en),
		.rgbl_i      (rgbl_i),
		.contrast_i  (contrast_i),
		.rgb_o       (rgb_o)
	);

endmodule

//--- hdl/vp_key_xlate.sv
// PS/2 and joystick numpad to ASCII key events for the keyboard matrix
// A PS/2 event wins over a joystick change in the same cycle
// Events arriving while one is held without key_ready_i are lost
module vp_key_xlate (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        core_reset_i,
	input  logic                        key_strobe_i,
	input  logic                        key_pressed_i,
	input  logic [vp_pkg::SCAN_W-1:0]   key_code_i,
	input  logic [vp_pkg::NUMPAD_W-1:0] joy_num_i,
	input  logic                        key_ready_i,
	output logic                        key_valid_o,
	output logic [7:0]                  key_ascii_o,
	output logic                        key_released_o
);
	import vp_pkg::*;

	logic                strobe_q;
	logic [NUMPAD_W-1:0] joy_q;
	logic                ps2_seen;
	logic                joy_seen;
	logic [7:0]          table_ascii;
	logic [7:0]          digit_ascii;
	// First stage, one slot per source
	logic                ps2_chg;
	logic                joy_chg;
	logic [7:0]          ps2_ascii;
	logic [7:0]          joy_ascii;
	logic                ps2_rel;
	logic                joy_rel;
	// Second stage, merged event
	logic                evt_valid;
	logic [7:0]          evt_ascii;
	logic                evt_rel;
	logic                load_out;

	assign ps2_seen = key_strobe_i ^ strobe_q;
	assign joy_seen = |(joy_num_i ^ joy_q);
	assign load_out = evt_valid & (~key_valid_o | key_ready_i);

	////////////////////
	// Scan code table
	////////////////////

	// Extended flag ignored
	always_comb begin
		case (key_code_i[7:0])
			8'h16: table_ascii = "1";
			8'h1e: table_ascii = "2";
			8'h26: table_ascii = "3";
			8'h25: table_ascii = "4";
			8'h2e: table_ascii = "5";
			8'h36: table_ascii = "6";
			8'h3d: table_ascii = "7";
			8'h3e: table_ascii = "8";
			8'h46: table_ascii = "9";
			8'h45: table_ascii = "0";
			8'h1c: table_ascii = "a";
			8'h32: table_ascii = "b";
			8'h21: table_ascii = "c";
			8'h23: table_ascii = "d";
			8'h24: table_ascii = "e";
			8'h2b: table_ascii = "f";
			8'h34: table_ascii = "g";
			8'h33: table_ascii = "h";
			8'h43: table_ascii = "i";
			8'h3b: table_ascii = "j";
			8'h42: table_ascii = "k";
			8'h4b: table_ascii = "l";
			8'h3a: table_ascii = "m";
			8'h31: table_ascii = "n";
			8'h44: table_ascii = "o";
			8'h4d: table_ascii = "p";
			8'h15: table_ascii = "q";
			8'h2d: table_ascii = "r";
			8'h1b: table_ascii = "s";
			8'h2c: table_ascii = "t";
			8'h3c: table_ascii = "u";
			8'h2a: table_ascii = "v";
			8'h1d: table_ascii = "w";
			8'h22: table_ascii = "x";
			8'h35: table_ascii = "y";
			8'h1a: table_ascii = "z";
			8'h29: table_ascii = " ";
			8'h79: table_ascii = "+";
			8'h7b: table_ascii = "-";
			8'h7c: table_ascii = "*";
			8'h4a: table_ascii = "/";
			8'h55: table_ascii = "=";
			// GUI keys act as yes and no
			8'h1f: table_ascii = 8'h11;
			8'h27: table_ascii = 8'h12;
			8'h5a: table_ascii = 8'd10;
			8'h66: table_ascii = 8'd8;
			default: table_ascii = 8'h00;
		endcase
	end

	// Lowest pressed button wins, top bit is the zero key
	always_comb begin
		digit_ascii = 8'h00;
		for (int i = NUMPAD_W - 1; i >= 0; i--) begin
			if (joy_num_i[i]) begin
				digit_ascii = (i == NUMPAD_W - 1) ? "0" : 8'("1" + i);
			end
		end
	end

	////////////////////
	// Event pipeline
	////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			strobe_q    <= 1'b0;
			joy_q       <= '0;
			ps2_chg     <= 1'b0;
			joy_chg     <= 1'b0;
			evt_valid   <= 1'b0;
			key_valid_o <= 1'b0;
		end else begin
			// Inputs still tracked under core reset so no stale edge appears later
			strobe_q <= key_strobe_i;
			joy_q    <= joy_num_i;
			if (core_reset_i) begin
				ps2_chg     <= 1'b0;
				joy_chg     <= 1'b0;
				evt_valid   <= 1'b0;
				key_valid_o <= 1'b0;
			end else begin
				ps2_chg   <= ps2_seen;
				joy_chg   <= joy_seen;
				evt_valid <= ps2_chg | joy_chg;
				if (load_out) begin
					key_valid_o <= 1'b1;
				end else if (key_ready_i) begin
					key_valid_o <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		ps2_ascii <= table_ascii;
		ps2_rel   <= ~key_pressed_i;
		joy_ascii <= digit_ascii;
		// All buttons up reads as a release
		joy_rel   <= ~|joy_num_i;
		evt_ascii <= ps2_chg ? ps2_ascii : joy_ascii;
		evt_rel   <= ps2_chg ? ps2_rel : joy_rel;
		if (load_out) begin
			key_ascii_o    <= evt_ascii;
			key_released_o <= evt_rel;
		end
	end

endmodule

//--- hdl/vp_palette.sv
// Palette lookup with the G7200 contrast variants
// Contrast 0 and 4 pass the palette through, 1..3 lead with red, 5..7 with blue
// Output updates only on pixel enable cycles, black under core reset
module vp_palette (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        core_reset_i,
	input  logic        pix_en_i,
	input  logic [3:0]  rgbl_i,
	input  logic [2:0]  contrast_i,
	output logic [23:0] rgb_o
);
	import vp_pkg::*;

	logic [23:0] base;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;
	logic [23:0] spliced;

	// Leading channel shifted down by 1, 2 or 4 bits
	// Gaps filled with the top bits of the tail or green channel
	function automatic logic [23:0] splice(input logic [7:0] lead, input logic [7:0] tail,
			input logic [7:0] grn, input logic [1:0] sel);
		case (sel)
			2'd1: splice = {lead[7:1], tail[7], grn[7], lead[7:1], lead[7:1], tail[7]};
			2'd2: splice = {lead[7:2], tail[7:6], grn[7:6], lead[7:2], lead[7:2], tail[7:6]};
			default: splice = {lead[7:4], tail[7:4], grn[7:4], lead[7:4], lead[7:4], tail[7:4]};
		endcase
	endfunction

	assign base  = PALETTE[rgbl_i];
	assign red   = base[23:16];
	assign green = base[15:8];
	assign blue  = base[7:0];

	always_comb begin
		case (contrast_i)
			3'd1: spliced = splice(red, blue, green, 2'd1);
			3'd2: spliced = splice(red, blue, green, 2'd2);
			3'd3: spliced = splice(red, blue, green, 2'd3);
			// Blue leading, mirror order
			3'd5: spliced = splice(blue, red, green, 2'd3);
			3'd6: spliced = splice(blue, red, green, 2'd2);
			3'd7: spliced = splice(blue, red, green, 2'd1);
			default: spliced = base;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else if (core_reset_i) begin
			rgb_o <= '0;
		end else if (pix_en_i) begin
			rgb_o <= spliced;
		end
	end

endmodule

//--- hdl/vp_pkg.sv
// Shared types, widths and palette of the Videopac glue logic
// Palette index is {r, g, b, luma} as driven by the VDC
package vp_pkg;

	////////////////////
	// Widths
	////////////////////

	// ROM holds up to 16 KiB of cartridge data
	localparam int ROM_AW = 14;
	// Console side cartridge address
	localparam int CART_AW = 12;
	// PS/2 code with extended flag in the top bit
	localparam int SCAN_W = 9;
	// Numpad buttons on the joystick, digits 1..9 then 0
	localparam int NUMPAD_W = 10;

	////////////////////
	// Types
	////////////////////

	// Cartridge size class, decided when a download ends
	typedef enum logic [1:0] {SIZE_2K, SIZE_4K, SIZE_8K, SIZE_12K} size_class_e;

	// System controller states
	typedef enum logic [1:0] {ST_RESET, ST_LOAD, ST_RUN} ctrl_state_e;

	////////////////////
	// Calibrated palette
	////////////////////

	localparam logic [23:0] PALETTE [16] = '{
		24'h000000,
		24'h676767,
		24'h1a37be,
		24'h5c80f6,
		24'h006d07,
		24'h56c469,
		24'h2aaabe,
		24'h77e6eb,
		24'h790000,
		24'hc75151,
		24'h94309f,
		24'hdc84e8,
		24'h77670b,
		24'hc6b86a,
		24'hcecece,
		24'hffffff
	};

endpackage

//--- hdl/vp_sys_ctrl.sv
// System reset and download tracking
// Write count saturates, so an oversized image falls back to SIZE_2K
// sys_reset_o follows dl_active_i one cycle late, plus one cycle per pal_i change
module vp_sys_ctrl (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                pal_i,
	input  logic                dl_active_i,
	input  logic                dl_wr_i,
	input  logic                dl_xrom_i,
	output logic                sys_reset_o,
	output logic                core_reset_o,
	output vp_pkg::size_class_e size_class_o,
	output logic                xrom_o
);
	import vp_pkg::*;

	// Two spare bits above the largest image size
	localparam int CNT_W = ROM_AW + 2;

	ctrl_state_e      state;
	logic             pal_q;
	logic             dl_active_q;
	logic [CNT_W-1:0] wr_count;
	logic             dl_rise;
	logic             dl_fall;
	logic             pal_change;

	// Exact image sizes only, anything else runs as a 2K cartridge
	function automatic size_class_e classify(input logic [CNT_W-1:0] n);
		case (n)
			CNT_W'(2 ** CART_AW): classify = SIZE_4K;
			CNT_W'(2 ** (CART_AW + 1)): classify = SIZE_8K;
			CNT_W'(2 ** ROM_AW): classify = SIZE_12K;
			default: classify = SIZE_2K;
		endcase
	endfunction

	assign dl_rise    = dl_active_i & ~dl_active_q;
	assign dl_fall    = ~dl_active_i & dl_active_q;
	assign pal_change = pal_i ^ pal_q;

	// Core held while not running or while the system reset is up
	assign core_reset_o = sys_reset_o | (state != ST_RUN);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state        <= ST_RESET;
			pal_q        <= 1'b0;
			dl_active_q  <= 1'b0;
			sys_reset_o  <= 1'b0;
			wr_count     <= '0;
			size_class_o <= SIZE_2K;
			xrom_o       <= 1'b0;
		end else begin
			pal_q       <= pal_i;
			dl_active_q <= dl_active_i;
			// Standard change also retimes the clock enables
			sys_reset_o <= dl_active_i | pal_change;

			case (state)
				ST_RESET: state <= dl_active_i ? ST_LOAD : ST_RUN;
				ST_RUN: if (dl_rise) state <= ST_LOAD;
				ST_LOAD: begin
					if (dl_fall) begin
						state        <= ST_RUN;
						size_class_o <= classify(wr_count);
					end
				end
				default: state <= ST_RESET;
			endcase

			// New image restarts the count, first write may land on the same edge
			if (dl_rise) begin
				wr_count <= CNT_W'(dl_wr_i);
				xrom_o   <= dl_xrom_i;
			end else if (dl_active_i && dl_wr_i && !(&wr_count)) begin
				wr_count <= wr_count + CNT_W'(1);
			end
		end
	end

endmodule

//--- include/vp_defs.svh
// Width macros shared by port lists of the top level and the ROM
// Include path must point at this folder
`ifndef VP_DEFS_SVH
`define VP_DEFS_SVH

// Data byte of the ROM download and cartridge read ports
`define VP_DATA_W 8

`endif

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module vp_tb -o vp_sim --Mdir obj_dir
./obj_dir/vp_sim > sim.log
cat sim.log

if grep -q "Simulation passed" sim.log; then
	exit 0
fi
exit 1
